/* wb_cache.f */
design/wb_cache_pkg.sv
design/cache_data_way.sv
design/cache_tag_store.sv
design/cache_controller.sv
design/wb_cache_top.sv
testbench/tb_clock_gen.sv
testbench/tb_wb_cache.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the write-back cache testbench with Verilator, runs it,
# and decides pass or fail from the simulation log.

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing -Wno-fatal -j 0 --top-module tb_wb_cache \
  -f wb_cache.f -o tb_wb_cache \
  && ./obj_dir/tb_wb_cache > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "Build or run failed"; exit 1; }

cat sim.log
grep -q "^Finished with no errors$" sim.log && exit 0 || exit 1

/* testbench/tb_wb_cache.sv */
//##########################################################
// Write-back cache testbench
// Random reads and writes against a reference memory model,
// a backing-RAM model with random delays and busy cycles,
// and DMA line invalidation.
//##########################################################
`default_nettype none

module tb_wb_cache;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int RAM_WORDS   = 1 << (wb_cache_pkg::ADDR_W - 2);
  localparam int CACHE_WORDS = wb_cache_pkg::WAYS * wb_cache_pkg::SETS * wb_cache_pkg::LINE_WORDS;
  // Four cache sizes of traffic whose top quarter is only ever read.
  localparam int WR_WORDS    = 3 * CACHE_WORDS;
  localparam int RO_WORDS    = CACHE_WORDS;
  localparam int N_OPS       = 600;
  localparam int N_INV       = 8;
  localparam int FAST_DELAY  = 3;
  localparam int SLOW_DELAY  = 12;
  localparam int BUSY_RUN    = 4;
  localparam int MISS_CYCLES = 2 * wb_cache_pkg::LINE_WORDS * (SLOW_DELAY + BUSY_RUN + 4) + 8;
  localparam int TOTAL_OPS   = 2 * N_OPS + 2 * N_INV + 16;
  localparam int TIMEOUT_NS  = (TOTAL_OPS * MISS_CYCLES + 100) * 10;

  logic                   clk;
  logic                   arst_n;
  wb_cache_pkg::cpu_req_t cpu_req;
  logic                   inv_valid;
  wb_cache_pkg::addr_t    inv_addr;
  wb_cache_pkg::data_t    ram_rdata;
  logic                   ram_ready;
  logic                   ram_busy;
  wb_cache_pkg::data_t    rdata;
  logic                   success;
  logic                   ram_req;
  wb_cache_pkg::ram_req_t ram_cmd;

  wb_cache_pkg::data_t ram_mem [RAM_WORDS];
  wb_cache_pkg::data_t ref_mem [RAM_WORDS];

  int seed = 32'h3f1;
  // The RAM model draws its own stream from the same seed.
  int ram_seed = 32'h3f1 ^ 32'h0000_5a5a;
  int max_delay = FAST_DELAY;
  int busy_pct = 10;
  int checks = 0;
  int errors = 0;
  int cmd_checks = 0;
  int cmd_errors = 0;
  int start_checks = 0;
  int start_errors = 0;
  int start_cmd_checks = 0;
  int start_cmd_errors = 0;

  tb_clock_gen i_clock_gen (
    .clk    (clk),
    .arst_n (arst_n)
  );

  wb_cache_top i_wb_cache_top (
    .clk       (clk),
    .arst_n    (arst_n),
    .cpu_req   (cpu_req),
    .inv_valid (inv_valid),
    .inv_addr  (inv_addr),
    .ram_rdata (ram_rdata),
    .ram_ready (ram_ready),
    .ram_busy  (ram_busy),
    .rdata     (rdata),
    .success   (success),
    .ram_req   (ram_req),
    .ram_cmd   (ram_cmd)
  );

  // Initial memory contents differ for every word address.
  function automatic wb_cache_pkg::data_t fill_pattern(int word);
    return 32'h5a00_0000 ^ (word * 32'h0001_0003) ^ (word << 20);
  endfunction

  function automatic wb_cache_pkg::data_t apply_write(wb_cache_pkg::data_t old_word,
                                                      wb_cache_pkg::data_t new_word,
                                                      wb_cache_pkg::be_t be);
    wb_cache_pkg::data_t mask;
    mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    return (old_word & ~mask) | (new_word & mask);
  endfunction

  task automatic check_word(input string what, input wb_cache_pkg::data_t got,
                            input wb_cache_pkg::data_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t ns: %s returned %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_ram_cmd(input wb_cache_pkg::ram_req_t got,
                               input wb_cache_pkg::ram_req_t exp);
    checks++;
    cmd_checks++;
    if (got !== exp) begin
      errors++;
      cmd_errors++;
      $display("FAIL %0t ns: RAM beat we/be/addr/data %b/%h/%h/%h, expected %b/%h/%h/%h",
               $time, got.we, got.be, got.addr, got.wdata, exp.we, exp.be, exp.addr, exp.wdata);
    end
  endtask

  task automatic mark_start();
    start_checks     = checks;
    start_errors     = errors;
    start_cmd_checks = cmd_checks;
    start_cmd_errors = cmd_errors;
  endtask

  task automatic report_test(input int num, input string name);
    $display("Test %0d %s: %0d checks, %0d errors", num, name,
             checks - start_checks, errors - start_errors);
    mark_start();
  endtask

  task automatic report_traffic(input int rd_num, input int wb_num, input string cond);
    int cmd_chk;
    int cmd_err;
    cmd_chk = cmd_checks - start_cmd_checks;
    cmd_err = cmd_errors - start_cmd_errors;
    $display("Test %0d random traffic%s: %0d checks, %0d errors", rd_num, cond,
             checks - start_checks - cmd_chk, errors - start_errors - cmd_err);
    $display("Test %0d RAM beats%s: %0d checks, %0d errors", wb_num, cond, cmd_chk, cmd_err);
    mark_start();
  endtask

  // Holds one request until success and checks it against the reference model.
  task automatic run_access(input logic rd, input wb_cache_pkg::be_t be,
                            input wb_cache_pkg::addr_t addr, input wb_cache_pkg::data_t wdata);
    int word;
    wb_cache_pkg::data_t expected;
    word     = int'(addr >> 2);
    expected = apply_write(ref_mem[word], wdata, be);
    cpu_req  = '{rd: rd, be: be, addr: addr, wdata: wdata};
    do begin
      @(negedge clk);
    end while (!success);
    check_word($sformatf("%s at %h", rd ? "read" : "write", addr), rdata, expected);
    ref_mem[word] = expected;
    cpu_req       = '0;
  endtask

  task automatic random_traffic(input int n_ops);
    int word;
    logic is_write;
    wb_cache_pkg::be_t be;
    for (int i = 0; i < n_ops; i++) begin
      word     = $unsigned($random(seed)) % (WR_WORDS + RO_WORDS);
      is_write = (word < WR_WORDS) && (($unsigned($random(seed)) % 100) < 45);
      be       = wb_cache_pkg::be_t'($random(seed));
      if (is_write) begin
        run_access(1'b0, (be == '0) ? 4'hf : be, wb_cache_pkg::addr_t'(word * 4), $random(seed));
      end else begin
        run_access(1'b1, '0, wb_cache_pkg::addr_t'(word * 4), '0);
      end
    end
  endtask

  // The backing RAM answers one beat at a time after a random delay.
  initial begin : ram_model
    int delay;
    int busy_count;
    int word;
    int wr_beats;
    int rd_beats;
    logic outstanding;
    logic exp_we;
    wb_cache_pkg::addr_t line_mask;
    wb_cache_pkg::addr_t set_mask;
    wb_cache_pkg::addr_t exp_addr;
    wb_cache_pkg::ram_req_t cmd;
    wb_cache_pkg::ram_req_t exp_cmd;
    ram_ready   = 1'b0;
    ram_busy    = 1'b0;
    ram_rdata   = '0;
    delay       = 0;
    busy_count  = 0;
    word        = 0;
    wr_beats    = 0;
    rd_beats    = 0;
    outstanding = 1'b0;
    line_mask   = wb_cache_pkg::addr_t'(wb_cache_pkg::LINE_WORDS * 4 - 1);
    set_mask    = wb_cache_pkg::addr_t'(wb_cache_pkg::SETS * wb_cache_pkg::LINE_WORDS * 4 - 1);
    forever begin
      @(negedge clk);
      ram_ready = 1'b0;
      // A finished request ends its burst sequence.
      if (success) begin
        wr_beats = 0;
        rd_beats = 0;
      end
      // Busy comes in bounded runs, so every beat is issued in the end.
      if (busy_count < BUSY_RUN && ($unsigned($random(ram_seed)) % 100) < busy_pct) begin
        ram_busy = 1'b1;
        busy_count++;
      end else begin
        ram_busy   = 1'b0;
        busy_count = 0;
      end
      if (ram_req) begin
        if (outstanding) begin
          errors++;
          $display("RAM beat issued at %0t ns before the previous beat was answered", $time);
        end
        cmd = ram_cmd;
        // Only the first beat of a miss shows whether the victim was dirty.
        exp_we = (rd_beats == 0) && (wr_beats < wb_cache_pkg::LINE_WORDS) &&
                 (cmd.we || wr_beats != 0);
        if (exp_we) begin
          // A writeback keeps the victim tag and walks the requested set in order.
          exp_addr = (cmd.addr & ~set_mask) | (cpu_req.addr & set_mask & ~line_mask) |
                     wb_cache_pkg::addr_t'(wr_beats * 4);
          wr_beats++;
        end else begin
          exp_addr = (cpu_req.addr & ~line_mask) | wb_cache_pkg::addr_t'(rd_beats * 4);
          rd_beats++;
        end
        exp_cmd = '{we:    exp_we,
                    be:    {wb_cache_pkg::BE_W{exp_we}},
                    addr:  exp_addr,
                    wdata: exp_we ? ref_mem[int'(exp_addr >> 2)] : wb_cache_pkg::data_t'(0)};
        check_ram_cmd(cmd, exp_cmd);
        word = int'(cmd.addr >> 2);
        if (cmd.we) begin
          ram_mem[word] = cmd.wdata;
        end
        delay       = $unsigned($random(ram_seed)) % (max_delay + 1);
        outstanding = 1'b1;
      end
      if (outstanding) begin
        if (delay == 0) begin
          ram_ready   = 1'b1;
          ram_rdata   = ram_mem[word];
          outstanding = 1'b0;
        end else begin
          delay--;
        end
      end
    end
  end

  initial begin : stimulus
    int word;
    wb_cache_pkg::addr_t addr;
    wb_cache_pkg::be_t be;
    cpu_req   = '0;
    inv_valid = 1'b0;
    inv_addr  = '0;
    for (int i = 0; i < RAM_WORDS; i++) begin
      ram_mem[i] = fill_pattern(i);
      ref_mem[i] = ram_mem[i];
    end
    wait (arst_n === 1'b1);
    @(negedge clk);

    repeat (20) begin
      @(negedge clk);
      checks++;
      if (success !== 1'b0 || ram_req !== 1'b0) begin
        errors++;
        $display("success or ram_req went high at %0t ns with no request applied", $time);
      end
    end
    report_test(1, "idle after reset");

    repeat (8) begin
      addr = wb_cache_pkg::addr_t'(($unsigned($random(seed)) % WR_WORDS) * 4);
      be   = wb_cache_pkg::be_t'($random(seed));
      run_access(1'b0, (be == '0) ? 4'b0001 : be, addr, $random(seed));
      run_access(1'b1, '0, addr, '0);
    end
    report_test(2, "write then read");

    random_traffic(N_OPS);
    report_traffic(3, 4, "");

    // Bring a read-only line in, change RAM behind it, then invalidate.
    repeat (N_INV) begin
      word = WR_WORDS + ($unsigned($random(seed)) % RO_WORDS);
      addr = wb_cache_pkg::addr_t'(word * 4);
      run_access(1'b1, '0, addr, '0);
      ram_mem[word] = $random(seed);
      ref_mem[word] = ram_mem[word];
      inv_valid     = 1'b1;
      inv_addr      = addr;
      @(negedge clk);
      inv_valid = 1'b0;
      run_access(1'b1, '0, addr, '0);
    end
    report_test(5, "DMA invalidation");

    max_delay = SLOW_DELAY;
    busy_pct  = 70;
    random_traffic(N_OPS);
    report_traffic(6, 6, " under back-pressure");

    $display("Total: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  initial begin : watchdog
    #(TIMEOUT_NS);
    $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
    $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire

/* testbench/tb_clock_gen.sv */
//##########################################################
// Testbench clock and reset
// 10 ns clock with an active-low reset held for 4 cycles.
//##########################################################
`default_nettype none

module tb_clock_gen (
  output logic clk,
  output logic arst_n
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Reset is released on a falling edge.
  initial begin
    arst_n = 1'b0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
  end

endmodule

`default_nettype wire

/* design/wb_cache_top.sv */
//##########################################################
// Write-back cache top level
// Two-way set-associative cache for one requester with an
// SRAM-like backing memory port and DMA line invalidation.
//##########################################################
`default_nettype none

module wb_cache_top (
  input  wire                          clk,
  input  wire                          arst_n,
  input  wire wb_cache_pkg::cpu_req_t  cpu_req,
  input  wire                          inv_valid,
  input  wire wb_cache_pkg::addr_t     inv_addr,
  input  wire wb_cache_pkg::data_t     ram_rdata,
  input  wire                          ram_ready,
  input  wire                          ram_busy,
  output wb_cache_pkg::data_t          rdata,
  output logic                         success,
  output logic                         ram_req,
  output wb_cache_pkg::ram_req_t       ram_cmd
);

  wb_cache_pkg::way_port_t way0_port;
  wb_cache_pkg::way_port_t way1_port;
  wb_cache_pkg::data_t     way0_q;
  wb_cache_pkg::data_t     way1_q;
  wb_cache_pkg::addr_t     lookup_addr;
  wb_cache_pkg::tag_t      victim_tag;
  logic                    hit;
  logic                    hit_way;
  logic                    victim_way;
  logic                    victim_dirty;
  logic                    install;
  logic                    install_way;
  logic                    install_dirty;
  logic                    mark_dirty;
  logic                    touch_way;
  logic                    idle;

  cache_controller i_cache_controller (
    .clk          (clk),
    .arst_n       (arst_n),
    .cpu_req      (cpu_req),
    .hit          (hit),
    .hit_way      (hit_way),
    .victim_way   (victim_way),
    .victim_tag   (victim_tag),
    .victim_dirty (victim_dirty),
    .way0_q       (way0_q),
    .way1_q       (way1_q),
    .ram_rdata    (ram_rdata),
    .ram_ready    (ram_ready),
    .ram_busy     (ram_busy),
    .rdata        (rdata),
    .success      (success),
    .ram_req      (ram_req),
    .ram_cmd      (ram_cmd),
    .way0_port    (way0_port),
    .way1_port    (way1_port),
    .lookup_addr  (lookup_addr),
    .install      (install),
    .install_way  (install_way),
    .install_dirty(install_dirty),
    .mark_dirty   (mark_dirty),
    .touch_way    (touch_way),
    .idle         (idle)
  );

  // Tag state sits beside the controller that steers it.
  cache_tag_store i_cache_tag_store (
    .clk          (clk),
    .arst_n       (arst_n),
    .lookup_addr  (lookup_addr),
    .install      (install),
    .install_way  (install_way),
    .install_dirty(install_dirty),
    .mark_dirty   (mark_dirty),
    .touch_way    (touch_way),
    .idle         (idle),
    .inv_valid    (inv_valid),
    .inv_addr     (inv_addr),
    .hit          (hit),
    .hit_way      (hit_way),
    .victim_way   (victim_way),
    .victim_tag   (victim_tag),
    .victim_dirty (victim_dirty)
  );

  cache_data_way i_cache_data_way0 (
    .clk  (clk),
    .port (way0_port),
    .q    (way0_q)
  );

  cache_data_way i_cache_data_way1 (
    .clk  (clk),
    .port (way1_port),
    .q    (way1_q)
  );

endmodule

`default_nettype wire

/* design/cache_controller.sv */
//##########################################################
// Cache controller
// Request FSM for lookup, dirty-line writeback and line
// refill, with byte merging of the pending write.
//##########################################################
`default_nettype none

module cache_controller (
  input  wire                             clk,
  input  wire                             arst_n,
  input  wire wb_cache_pkg::cpu_req_t     cpu_req,
  input  wire                             hit,
  input  wire                             hit_way,
  input  wire                             victim_way,
  input  wire wb_cache_pkg::tag_t         victim_tag,
  input  wire                             victim_dirty,
  input  wire wb_cache_pkg::data_t        way0_q,
  input  wire wb_cache_pkg::data_t        way1_q,
  input  wire wb_cache_pkg::data_t        ram_rdata,
  input  wire                             ram_ready,
  input  wire                             ram_busy,
  output wb_cache_pkg::data_t             rdata,
  output logic                            success,
  output logic                            ram_req,
  output wb_cache_pkg::ram_req_t          ram_cmd,
  output wb_cache_pkg::way_port_t         way0_port,
  output wb_cache_pkg::way_port_t         way1_port,
  output wb_cache_pkg::addr_t             lookup_addr,
  output logic                            install,
  output logic                            install_way,
  output logic                            install_dirty,
  output logic                            mark_dirty,
  output logic                            touch_way,
  output logic                            idle
);

  localparam int WAYS = wb_cache_pkg::WAYS;

  wb_cache_pkg::cache_state_e state;
  wb_cache_pkg::cpu_req_t     req;
  wb_cache_pkg::word_idx_t    beat;
  wb_cache_pkg::data_t        hold_word;
  logic                       pending;
  wb_cache_pkg::way_port_t    port_q [WAYS];
  wb_cache_pkg::data_t        way_q [WAYS];

  wb_cache_pkg::tag_t         req_tag;
  wb_cache_pkg::set_t         req_set;
  wb_cache_pkg::word_idx_t    req_word;
  logic                       req_write;
  logic                       last_beat;
  wb_cache_pkg::data_t        hit_merged;
  wb_cache_pkg::data_t        fill_word;

  // Byte lanes are little endian.
  function automatic wb_cache_pkg::data_t merge_bytes(wb_cache_pkg::data_t old_word,
                                                      wb_cache_pkg::data_t new_word,
                                                      wb_cache_pkg::be_t be);
    wb_cache_pkg::data_t result;
    result = old_word;
    for (int b = 0; b < wb_cache_pkg::BE_W; b++) begin
      if (be[b]) begin
        result[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return result;
  endfunction

  assign way_q[0]  = way0_q;
  assign way_q[1]  = way1_q;
  assign way0_port = port_q[0];
  assign way1_port = port_q[1];

  assign req_tag   = wb_cache_pkg::addr_tag(req.addr);
  assign req_set   = wb_cache_pkg::addr_set(req.addr);
  assign req_word  = wb_cache_pkg::addr_word(req.addr);
  assign req_write = |req.be;
  assign last_beat = (beat == wb_cache_pkg::word_idx_t'(wb_cache_pkg::LINE_WORDS - 1));

  // A read leaves the word as it is, since no lane is enabled.
  assign hit_merged = merge_bytes(way_q[hit_way], req.wdata, req.be);
  assign fill_word  = (beat == req_word) ? merge_bytes(ram_rdata, req.wdata, req.be)
                                         : ram_rdata;

  assign lookup_addr   = req.addr;
  assign idle          = (state == wb_cache_pkg::idle);
  assign touch_way     = (state == wb_cache_pkg::lookup_resp) && hit;
  assign mark_dirty    = touch_way && req_write;
  assign install       = (state == wb_cache_pkg::refill_wait) && ram_ready && last_beat;
  assign install_way   = victim_way;
  assign install_dirty = req_write;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state     <= wb_cache_pkg::idle;
      req       <= '0;
      beat      <= '0;
      hold_word <= '0;
      pending   <= 1'b0;
      success   <= 1'b0;
      rdata     <= '0;
      ram_req   <= 1'b0;
      ram_cmd   <= '0;
      for (int w = 0; w < WAYS; w++) begin
        port_q[w] <= '0;
      end
    end else begin
      // Strobes last one cycle; success trails the registered rdata.
      ram_req <= 1'b0;
      success <= pending;
      pending <= 1'b0;
      for (int w = 0; w < WAYS; w++) begin
        port_q[w].re <= 1'b0;
        port_q[w].we <= 1'b0;
      end

      case (state)
        wb_cache_pkg::idle: begin
          // The requester holds its request until success, so skip it
          // while the previous completion is still on its way out.
          if ((cpu_req.rd || (|cpu_req.be)) && !success && !pending) begin
            req   <= cpu_req;
            state <= wb_cache_pkg::lookup_rd;
          end
        end

        wb_cache_pkg::lookup_rd: begin
          for (int w = 0; w < WAYS; w++) begin
            port_q[w].re   <= 1'b1;
            port_q[w].addr <= {req_set, req_word};
          end
          state <= wb_cache_pkg::lookup_wait;
        end

        wb_cache_pkg::lookup_wait: begin
          state <= wb_cache_pkg::lookup_resp;
        end

        wb_cache_pkg::lookup_resp: begin
          if (hit) begin
            if (req_write) begin
              port_q[hit_way].we    <= 1'b1;
              port_q[hit_way].addr  <= {req_set, req_word};
              port_q[hit_way].wdata <= hit_merged;
            end
            rdata   <= hit_merged;
            pending <= 1'b1;
            state   <= wb_cache_pkg::idle;
          end else begin
            beat  <= '0;
            state <= victim_dirty ? wb_cache_pkg::wb_rd : wb_cache_pkg::refill_issue;
          end
        end

        // Victim line goes out to RAM one word at a time.
        wb_cache_pkg::wb_rd: begin
          port_q[victim_way].re   <= 1'b1;
          port_q[victim_way].addr <= {req_set, beat};
          state                   <= wb_cache_pkg::wb_rd_wait;
        end

        wb_cache_pkg::wb_rd_wait: begin
          state <= wb_cache_pkg::wb_issue;
        end

        wb_cache_pkg::wb_issue: begin
          if (!ram_busy) begin
            ram_req <= 1'b1;
            ram_cmd <= '{we:    1'b1,
                         be:    '1,
                         addr:  wb_cache_pkg::line_addr(victim_tag, req_set, beat),
                         wdata: way_q[victim_way]};
            state   <= wb_cache_pkg::wb_wait;
          end
        end

        wb_cache_pkg::wb_wait: begin
          if (ram_ready) begin
            beat  <= beat + 1'b1;
            state <= last_beat ? wb_cache_pkg::refill_issue : wb_cache_pkg::wb_rd;
          end
        end

        wb_cache_pkg::refill_issue: begin
          if (!ram_busy) begin
            ram_req <= 1'b1;
            ram_cmd <= '{we:    1'b0,
                         be:    '0,
                         addr:  wb_cache_pkg::line_addr(req_tag, req_set, beat),
                         wdata: '0};
            state   <= wb_cache_pkg::refill_wait;
          end
        end

        // Each returned word goes into the victim way, the requested
        // word with the pending write merged in.
        wb_cache_pkg::refill_wait: begin
          if (ram_ready) begin
            port_q[victim_way].we    <= 1'b1;
            port_q[victim_way].addr  <= {req_set, beat};
            port_q[victim_way].wdata <= fill_word;
            if (beat == req_word) begin
              hold_word <= fill_word;
            end
            beat <= beat + 1'b1;
            if (last_beat) begin
              rdata   <= (beat == req_word) ? fill_word : hold_word;
              pending <= 1'b1;
              state   <= wb_cache_pkg::idle;
            end else begin
              state <= wb_cache_pkg::refill_issue;
            end
          end
        end

        default: begin
          state <= wb_cache_pkg::idle;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* design/cache_tag_store.sv */
//##########################################################
// Cache tag store
// Per-set valid, dirty, tag and evictee state for both ways.
// Computes hit and victim, applies installs, dirty marks,
// LRU touches and DMA line invalidations.
//##########################################################
`default_nettype none

module cache_tag_store (
  input  wire                        clk,
  input  wire                        arst_n,
  input  wire wb_cache_pkg::addr_t   lookup_addr,
  input  wire                        install,
  input  wire                        install_way,
  input  wire                        install_dirty,
  input  wire                        mark_dirty,
  input  wire                        touch_way,
  input  wire                        idle,
  input  wire                        inv_valid,
  input  wire wb_cache_pkg::addr_t   inv_addr,
  output logic                       hit,
  output logic                       hit_way,
  output logic                       victim_way,
  output wb_cache_pkg::tag_t         victim_tag,
  output logic                       victim_dirty
);

  localparam int WAYS = wb_cache_pkg::WAYS;
  localparam int SETS = wb_cache_pkg::SETS;

  logic [WAYS-1:0][SETS-1:0] valid;
  logic [WAYS-1:0][SETS-1:0] dirty;
  // The evictee bit of a set names the way that is replaced next.
  logic [SETS-1:0]           evictee;
  wb_cache_pkg::tag_t        tags [WAYS][SETS];

  wb_cache_pkg::tag_t        tag;
  wb_cache_pkg::set_t        set;
  wb_cache_pkg::tag_t        inv_tag;
  wb_cache_pkg::set_t        inv_set;
  logic [WAYS-1:0]           way_hit;

  assign tag     = wb_cache_pkg::addr_tag(lookup_addr);
  assign set     = wb_cache_pkg::addr_set(lookup_addr);
  assign inv_tag = wb_cache_pkg::addr_tag(inv_addr);
  assign inv_set = wb_cache_pkg::addr_set(inv_addr);

  always_comb begin
    for (int w = 0; w < WAYS; w++) begin
      way_hit[w] = valid[w][set] && (tags[w][set] == tag);
    end
  end

  assign hit     = |way_hit;
  assign hit_way = way_hit[1];

  // An invalid way is filled first, way 0 before way 1.
  always_comb begin
    if (!valid[0][set]) begin
      victim_way = 1'b0;
    end else if (!valid[1][set]) begin
      victim_way = 1'b1;
    end else begin
      victim_way = evictee[set];
    end
  end

  assign victim_tag   = tags[victim_way][set];
  assign victim_dirty = valid[victim_way][set] && dirty[victim_way][set];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid   <= '0;
      dirty   <= '0;
      evictee <= '0;
    end else begin
      // DMA invalidation is taken only while the controller is idle.
      if (inv_valid && idle) begin
        for (int w = 0; w < WAYS; w++) begin
          if (valid[w][inv_set] && (tags[w][inv_set] == inv_tag)) begin
            valid[w][inv_set] <= 1'b0;
            dirty[w][inv_set] <= 1'b0;
          end
        end
      end
      if (install) begin
        valid[install_way][set] <= 1'b1;
        dirty[install_way][set] <= install_dirty;
        evictee[set]            <= ~install_way;
      end
      if (mark_dirty) begin
        dirty[hit_way][set] <= 1'b1;
      end
      // The other way becomes the next victim.
      if (touch_way) begin
        evictee[set] <= ~hit_way;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (install) begin
      tags[install_way][set] <= tag;
    end
  end

endmodule

`default_nettype wire

/* design/cache_data_way.sv */
//##########################################################
// Cache data way
// Single-port word array for one way, SETS x LINE_WORDS
// words, with a synchronous write and a registered read.
//##########################################################
`default_nettype none

module cache_data_way (
  input  wire                       clk,
  input  wire wb_cache_pkg::way_port_t port,
  output wb_cache_pkg::data_t       q
);

  // Block RAM style array indexed by {set, word}.
  wb_cache_pkg::data_t mem [wb_cache_pkg::WAY_DEPTH];

  always_ff @(posedge clk) begin
    if (port.we) begin
      mem[port.addr] <= port.wdata;
    end
    // Read data appears one cycle after re and holds until the next read.
    if (port.re) begin
      q <= mem[port.addr];
    end
  end

endmodule

`default_nettype wire

/* design/wb_cache_pkg.sv */
//##########################################################
// Write-back cache package
// Geometry, address fields, request structs and FSM states
// shared by every block of the two-way write-back cache.
//##########################################################
`default_nettype none

package wb_cache_pkg;

  // 16 sets of 8-word lines on a 16-bit byte address.
  localparam int ADDR_W     = 16;
  localparam int DATA_W     = 32;
  localparam int BE_W       = DATA_W / 8;
  localparam int LINE_WORDS = 8;
  localparam int SETS       = 16;
  localparam int WAYS       = 2;
  localparam int OFFSET_W   = $clog2(BE_W);
  localparam int WORD_W     = $clog2(LINE_WORDS);
  localparam int SET_W      = $clog2(SETS);
  localparam int TAG_W      = ADDR_W - SET_W - WORD_W - OFFSET_W;
  localparam int WAY_DEPTH  = SETS * LINE_WORDS;

  typedef logic [ADDR_W-1:0]       addr_t;
  typedef logic [DATA_W-1:0]       data_t;
  typedef logic [BE_W-1:0]         be_t;
  typedef logic [TAG_W-1:0]        tag_t;
  typedef logic [SET_W-1:0]        set_t;
  typedef logic [WORD_W-1:0]       word_idx_t;
  typedef logic [SET_W+WORD_W-1:0] way_addr_t;

  // A request is present when rd is set or any byte enable is set.
  typedef struct packed {
    logic  rd;
    be_t   be;
    addr_t addr;
    data_t wdata;
  } cpu_req_t;

  typedef struct packed {
    logic  we;
    be_t   be;
    addr_t addr;
    data_t wdata;
  } ram_req_t;

  typedef struct packed {
    logic      re;
    logic      we;
    way_addr_t addr;
    data_t     wdata;
  } way_port_t;

  typedef enum logic [3:0] {
    idle,
    lookup_rd,
    lookup_wait,
    lookup_resp,
    wb_rd,
    wb_rd_wait,
    wb_issue,
    wb_wait,
    refill_issue,
    refill_wait
  } cache_state_e;

  // Address layout is {tag, set, word, byte offset}.
  function automatic tag_t addr_tag(addr_t addr);
    return addr[ADDR_W-1 -: TAG_W];
  endfunction

  function automatic set_t addr_set(addr_t addr);
    return addr[OFFSET_W+WORD_W +: SET_W];
  endfunction

  function automatic word_idx_t addr_word(addr_t addr);
    return addr[OFFSET_W +: WORD_W];
  endfunction

  // Word-aligned byte address of one word in a line.
  function automatic addr_t line_addr(tag_t tag, set_t set, word_idx_t word);
    return {tag, set, word, {OFFSET_W{1'b0}}};
  endfunction

endpackage

`default_nettype wire
